// ==== logic/slurm16_config.svh ====
`ifndef SLURM16_CONFIG_SVH
`define SLURM16_CONFIG_SVH

// Instruction and data word width
`define SLURM_BITS 16

// Instruction memory address width
`define SLURM_ADDRESS_BITS 16

// Register index width, 16 registers
`define SLURM_REGISTER_BITS 4

// Entries in the alternate buffer, power of two
`define SLURM_ALT_DEPTH 8

// Fetch slots masked after reset or a branch
`define SLURM_PC_MASK 2

// Replay slots after a stall
`define SLURM_STALL_MASK 2

// Width of the mask counters
`define SLURM_MASK_BITS 2

`endif

// ==== logic/slurm16_isa_pkg.sv ====
`include "slurm16_config.svh"

package slurm16_isa_pkg;

	// Major opcode in bits 15 to 12
	typedef enum logic [3:0] {
		OP_MISC = 4'h0, // NOP and INT
		OP_IMM  = 4'h1, // Immediate prefix, 12 high bits
		OP_ALU  = 4'h2, // dst op src, sets flags
		OP_MOV  = 4'h3, // dst = src, flags untouched
		OP_BR   = 4'h4  // Relative branch
	} opcode_t;

	typedef logic [`SLURM_REGISTER_BITS - 1:0] reg_idx_t;

	// Register 0 doubles as "no hazard"
	localparam reg_idx_t R0 = '0;

	localparam logic [`SLURM_BITS - 1:0] NOP_INSTRUCTION = '0;

	// Low part of the immediate comes from the consuming instruction
	localparam int IMM_LO_BITS = 4;
	localparam int IMM_HI_BITS = `SLURM_BITS - IMM_LO_BITS;

	// Upper 12 bits of an INT word, irq number goes below
	localparam logic [IMM_HI_BITS - 1:0] INT_PREFIX = 12'h050;

	// Field layout
	localparam int OPCODE_MSB = 15;
	localparam int OPCODE_LSB = 12;
	localparam int DST_MSB    = 7;
	localparam int DST_LSB    = 4;
	localparam int SRC_MSB    = 3;
	localparam int SRC_LSB    = 0;
	localparam int BR_OFFSET_BITS = 8; // Signed offset in the low byte

	function automatic opcode_t opcode_of(input logic [`SLURM_BITS - 1:0] instr);
		return opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);
	endfunction

	function automatic reg_idx_t dst_of(input logic [`SLURM_BITS - 1:0] instr);
		return instr[DST_MSB:DST_LSB];
	endfunction

	function automatic reg_idx_t src_of(input logic [`SLURM_BITS - 1:0] instr);
		return instr[SRC_MSB:SRC_LSB];
	endfunction

endpackage

// ==== logic/slurm16_pipe_pkg.sv ====
package slurm16_pipe_pkg;

	// Fetch sequencer
	typedef enum logic {
		FETCH_IDLE, // Held, PC rewound to the unconsumed word
		FETCH_RUN
	} fetch_state_t;

	// Stall edge tracking
	typedef enum logic [1:0] {
		STALL_NONE,
		STALL_HOLD,    // Decode slot held
		STALL_RELEASE  // First cycle after the hold
	} stall_state_t;

endpackage

// ==== logic/slurm16_fetch.sv ====
`timescale 1ns/1ps
`include "slurm16_config.svh"

module slurm16_fetch (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              run,
	input  logic                              stall,
	input  logic                              load_pc,
	input  logic [`SLURM_ADDRESS_BITS - 1:0]  branch_target,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  fetch_addr,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  fetch_pc,
	output logic                              fetch_valid
);
	import slurm16_pipe_pkg::*;

	fetch_state_t state_r;
	logic [`SLURM_ADDRESS_BITS - 1:0] pc_r;
	logic [`SLURM_MASK_BITS - 1:0] mask_r;

	assign fetch_addr = pc_r;
	assign fetch_valid = (mask_r == '0); // Data on the bus belongs to the current stream

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r <= FETCH_IDLE;
			pc_r <= '0;
			fetch_pc <= '0;
			mask_r <= `SLURM_MASK_BITS'(`SLURM_PC_MASK);
		end else begin
			fetch_pc <= pc_r; // Memory answers one cycle later
			if (load_pc) begin
				pc_r <= branch_target;
				mask_r <= `SLURM_MASK_BITS'(`SLURM_PC_MASK);
			end else if (run) begin
				state_r <= FETCH_RUN;
				if (mask_r != '0)
					mask_r <= mask_r - 1'b1;
				// Target is issued twice, the first copy falls in a masked slot
				if (mask_r <= `SLURM_MASK_BITS'(1) && !stall)
					pc_r <= pc_r + 1'b1;
			end else begin
				state_r <= FETCH_IDLE;
				// Word on the bus is not consumed while halted, fetch it again
				if (state_r == FETCH_RUN && mask_r == '0)
					pc_r <= fetch_pc;
			end
		end
	end

endmodule

// ==== logic/slurm16_hazard_ctl.sv ====
`timescale 1ns/1ps
`include "slurm16_config.svh"

module slurm16_hazard_ctl (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              is_executing,
	input  logic [`SLURM_BITS - 1:0]          pipeline_stage0,
	input  logic [`SLURM_BITS - 1:0]          pipeline_stage1,
	input  logic [`SLURM_BITS - 1:0]          pipeline_stage2,
	input  logic [`SLURM_BITS - 1:0]          pipeline_stage3,
	input  logic [`SLURM_ADDRESS_BITS - 1:0]  pc_stage2,
	input  slurm16_isa_pkg::reg_idx_t         hazard_reg1,
	input  slurm16_isa_pkg::reg_idx_t         hazard_reg2,
	input  slurm16_isa_pkg::reg_idx_t         hazard_reg3,
	input  logic                              modifies_flags1,
	input  logic                              modifies_flags2,
	input  logic                              modifies_flags3,
	output slurm16_isa_pkg::reg_idx_t         hazard_reg0,
	output logic                              modifies_flags0,
	output logic                              stall,
	output logic                              stall_start,
	output logic                              stall_end,
	output logic                              hazard1,
	output logic                              load_pc,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  branch_target
);
	import slurm16_isa_pkg::*;
	import slurm16_pipe_pkg::*;

	opcode_t op0, op2;
	reg_idx_t src_a, src_b;
	logic reads_flags;
	logic clash1, clash2, clash3;
	stall_state_t state_r;

	// Does an older slot write something the decode slot reads
	function automatic logic clash(input reg_idx_t a, input reg_idx_t b, input logic rf,
		input reg_idx_t dst, input logic mf, input logic [`SLURM_BITS - 1:0] instr);
		logic reg_hit;
		reg_hit = (a != R0 && a == dst) || (b != R0 && b == dst);
		return (instr != NOP_INSTRUCTION) && (reg_hit || (rf && mf));
	endfunction

	always_comb begin
		op0 = opcode_of(pipeline_stage0);
		src_a = (op0 == OP_ALU || op0 == OP_MOV) ? src_of(pipeline_stage0) : R0;
		src_b = (op0 == OP_ALU) ? dst_of(pipeline_stage0) : R0; // ALU reads its destination
		reads_flags = (op0 == OP_BR);
		hazard_reg0 = (op0 == OP_ALU || op0 == OP_MOV) ? dst_of(pipeline_stage0) : R0;
		modifies_flags0 = (op0 == OP_ALU);

		clash1 = clash(src_a, src_b, reads_flags, hazard_reg1, modifies_flags1, pipeline_stage1);
		clash2 = clash(src_a, src_b, reads_flags, hazard_reg2, modifies_flags2, pipeline_stage2);
		clash3 = clash(src_a, src_b, reads_flags, hazard_reg3, modifies_flags3, pipeline_stage3);

		stall = is_executing && (clash1 || clash2 || clash3);
		hazard1 = stall && clash1 && !clash2 && !clash3;

		// Branch resolves in execute
		op2 = opcode_of(pipeline_stage2);
		load_pc = is_executing && (op2 == OP_BR);
	end

	assign branch_target = pc_stage2 + 1'b1
		+ `SLURM_ADDRESS_BITS'($signed(pipeline_stage2[BR_OFFSET_BITS - 1:0]));

	assign stall_start = stall && (state_r != STALL_HOLD);
	assign stall_end = !stall && (state_r == STALL_HOLD);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r <= STALL_NONE;
		end else begin
			case (state_r)
				STALL_NONE:    state_r <= stall ? STALL_HOLD : STALL_NONE;
				STALL_HOLD:    state_r <= stall ? STALL_HOLD : STALL_RELEASE;
				STALL_RELEASE: state_r <= stall ? STALL_HOLD : STALL_NONE;
				default:       state_r <= STALL_NONE;
			endcase
		end
	end

endmodule

// ==== logic/slurm16_cpu_pipeline.sv ====
`timescale 1ns/1ps
`include "slurm16_config.svh"

module slurm16_cpu_pipeline (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic [`SLURM_BITS - 1:0]          memory_in,
	input  logic [`SLURM_ADDRESS_BITS - 1:0]  memory_address, // Address of memory_in
	input  logic                              memory_is_instruction,
	input  logic                              is_executing,
	input  logic                              stall,
	input  logic                              stall_start,
	input  logic                              stall_end,
	input  logic                              load_pc,
	input  slurm16_isa_pkg::reg_idx_t         hazard_reg0,
	input  logic                              modifies_flags0,
	input  logic                              hazard1,
	input  logic                              interrupt_flag_set,
	input  logic                              interrupt_flag_clear,
	input  logic                              interrupt,
	input  logic [3:0]                        irq,
	output logic [`SLURM_BITS - 1:0]          pipeline_stage0,
	output logic [`SLURM_BITS - 1:0]          pipeline_stage1,
	output logic [`SLURM_BITS - 1:0]          pipeline_stage2,
	output logic [`SLURM_BITS - 1:0]          pipeline_stage3,
	output logic [`SLURM_BITS - 1:0]          pipeline_stage4,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  pc_stage2,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  pc_stage4,
	output logic [`SLURM_BITS - 1:0]          imm_reg,
	output slurm16_isa_pkg::reg_idx_t         hazard_reg1,
	output slurm16_isa_pkg::reg_idx_t         hazard_reg2,
	output slurm16_isa_pkg::reg_idx_t         hazard_reg3,
	output logic                              modifies_flags1,
	output logic                              modifies_flags2,
	output logic                              modifies_flags3
);
	import slurm16_isa_pkg::*;

	localparam int ALT_PTR_BITS = $clog2(`SLURM_ALT_DEPTH);

	logic [`SLURM_BITS - 1:0] stage_r [5];
	logic [`SLURM_BITS - 1:0] stage_next [5];
	logic [`SLURM_ADDRESS_BITS - 1:0] pc_r [5];
	logic [`SLURM_ADDRESS_BITS - 1:0] pc_next [5];
	reg_idx_t hazard_r [1:3];
	reg_idx_t hazard_next [1:3];
	logic flags_r [1:3];
	logic flags_next [1:3];

	// Alternate buffer for words that cannot enter stage 0 yet
	logic [`SLURM_BITS - 1:0] alt_instr [`SLURM_ALT_DEPTH];
	logic [`SLURM_ADDRESS_BITS - 1:0] alt_pc [`SLURM_ALT_DEPTH];
	logic [ALT_PTR_BITS - 1:0] wr_ptr_r, rd_ptr_r, wr_idx;

	logic [`SLURM_MASK_BITS - 1:0] mask_cnt_r, stall_mask_r;
	logic [`SLURM_ADDRESS_BITS - 1:0] next_pc_r; // Next sequential word expected
	logic seq_r;
	logic interrupt_flag_r;
	logic [IMM_HI_BITS - 1:0] imm_r;
	logic [`SLURM_BITS - 1:0] imm_stage2_r;

	logic fifo_empty, advance, inject, live_ok, take_fifo, take_live, push, realign;
	logic stage2_load;

	assign fifo_empty = (wr_ptr_r == rd_ptr_r);
	assign advance = is_executing && !stall;
	assign inject = advance && !load_pc && interrupt_flag_r && interrupt && mask_cnt_r == '0;
	// Reissued copies of a word already taken are dropped here
	assign live_ok = is_executing && !load_pc && memory_is_instruction && mask_cnt_r == '0
		&& (!seq_r || memory_address == next_pc_r);
	assign take_fifo = advance && !fifo_empty && !inject;
	assign take_live = advance && fifo_empty && !inject && live_ok;
	assign push = live_ok && !take_live;
	assign realign = stall_start && fifo_empty && stall_mask_r == '0;
	assign wr_idx = realign ? '0 : wr_ptr_r;
	assign stage2_load = is_executing && (!stall || hazard1);

	always_comb begin
		stage_next = stage_r;
		pc_next = pc_r;
		hazard_next = hazard_r;
		flags_next = flags_r;
		stage_next[4] = NOP_INSTRUCTION; // Retire slot shows a word for one cycle only

		if (advance) begin
			if (inject) begin
				stage_next[0] = {INT_PREFIX, irq};
				pc_next[0] = fifo_empty ? next_pc_r : alt_pc[rd_ptr_r]; // Return address
			end else if (take_fifo) begin
				stage_next[0] = alt_instr[rd_ptr_r];
				pc_next[0] = alt_pc[rd_ptr_r];
			end else if (take_live) begin
				stage_next[0] = memory_in;
				pc_next[0] = memory_address;
			end else begin
				stage_next[0] = NOP_INSTRUCTION;
			end
			for (int i = 1; i < 5; i++) begin
				stage_next[i] = stage_r[i - 1];
				pc_next[i] = pc_r[i - 1];
			end
			hazard_next[1] = hazard_reg0;
			flags_next[1] = modifies_flags0;
			for (int i = 2; i < 4; i++) begin
				hazard_next[i] = hazard_r[i - 1];
				flags_next[i] = flags_r[i - 1];
			end
		end else if (is_executing) begin
			// Hold decode, bubble into execute
			stage_next[2] = NOP_INSTRUCTION;
			stage_next[3] = stage_r[2];
			stage_next[4] = stage_r[3];
			pc_next[3] = pc_r[2];
			pc_next[4] = pc_r[3];
			hazard_next[2] = R0;
			hazard_next[3] = hazard_r[2];
			flags_next[2] = 1'b0;
			flags_next[3] = flags_r[2];
			if (hazard1) begin // Conflict only with stage 1, let it move on
				stage_next[1] = NOP_INSTRUCTION;
				stage_next[2] = stage_r[1];
				pc_next[2] = pc_r[1];
				hazard_next[1] = R0;
				hazard_next[2] = hazard_r[1];
				flags_next[1] = 1'b0;
				flags_next[2] = flags_r[1];
			end
		end

		if (load_pc) begin
			for (int i = 0; i < 3; i++)
				stage_next[i] = NOP_INSTRUCTION;
			hazard_next[1] = R0;
			hazard_next[2] = R0;
			flags_next[1] = 1'b0;
			flags_next[2] = 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 5; i++)
				stage_r[i] <= NOP_INSTRUCTION;
			for (int i = 1; i < 4; i++) begin
				hazard_r[i] <= R0;
				flags_r[i] <= 1'b0;
			end
			mask_cnt_r <= `SLURM_MASK_BITS'(`SLURM_PC_MASK);
			stall_mask_r <= '0;
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			seq_r <= 1'b0;
			next_pc_r <= '0;
			interrupt_flag_r <= 1'b0;
			imm_r <= '0;
		end else begin
			stage_r <= stage_next;
			hazard_r <= hazard_next;
			flags_r <= flags_next;

			if (load_pc)
				mask_cnt_r <= `SLURM_MASK_BITS'(`SLURM_PC_MASK);
			else if (is_executing && mask_cnt_r != '0)
				mask_cnt_r <= mask_cnt_r - 1'b1;

			if (stall_end)
				stall_mask_r <= `SLURM_MASK_BITS'(`SLURM_STALL_MASK);
			else if (is_executing && stall_mask_r != '0)
				stall_mask_r <= stall_mask_r - 1'b1;

			// Buffer pointers
			if (load_pc) begin
				wr_ptr_r <= '0;
				rd_ptr_r <= '0;
			end else begin
				if (push)
					wr_ptr_r <= wr_idx + 1'b1;
				else if (realign)
					wr_ptr_r <= '0;
				if (realign)
					rd_ptr_r <= '0;
				else if (take_fifo)
					rd_ptr_r <= rd_ptr_r + 1'b1;
			end

			if (load_pc) begin
				seq_r <= 1'b0;
			end else if (push || take_live) begin
				seq_r <= 1'b1;
				next_pc_r <= memory_address + 1'b1;
			end

			if (interrupt_flag_clear || inject)
				interrupt_flag_r <= 1'b0;
			else if (interrupt_flag_set)
				interrupt_flag_r <= 1'b1;

			// High part follows the IMM prefix into execute
			if (load_pc)
				imm_r <= '0;
			else if (stage2_load && stage_r[1] != NOP_INSTRUCTION)
				imm_r <= (opcode_of(stage_r[1]) == OP_IMM) ? stage_r[1][IMM_HI_BITS - 1:0] : '0;
		end
	end

	always_ff @(posedge CLK) begin
		pc_r <= pc_next;
		if (stage2_load)
			imm_stage2_r <= {imm_r, stage_r[1][IMM_LO_BITS - 1:0]};
		if (push) begin
			alt_instr[wr_idx] <= memory_in;
			alt_pc[wr_idx] <= memory_address;
		end
	end

	assign pipeline_stage0 = stage_r[0];
	assign pipeline_stage1 = stage_r[1];
	assign pipeline_stage2 = stage_r[2];
	assign pipeline_stage3 = stage_r[3];
	assign pipeline_stage4 = stage_r[4];
	assign pc_stage2 = pc_r[2];
	assign pc_stage4 = pc_r[4];
	assign imm_reg = imm_stage2_r;
	assign hazard_reg1 = hazard_r[1];
	assign hazard_reg2 = hazard_r[2];
	assign hazard_reg3 = hazard_r[3];
	assign modifies_flags1 = flags_r[1];
	assign modifies_flags2 = flags_r[2];
	assign modifies_flags3 = flags_r[3];

endmodule

// ==== logic/slurm16_frontend.sv ====
`timescale 1ns/1ps
`include "slurm16_config.svh"

module slurm16_frontend (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              run,
	input  logic [`SLURM_BITS - 1:0]          mem_data,
	input  logic                              interrupt,
	input  logic [3:0]                        irq,
	input  logic                              int_flag_set,
	input  logic                              int_flag_clear,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  mem_addr,
	output logic [`SLURM_BITS - 1:0]          exec_instr,
	output logic [`SLURM_BITS - 1:0]          exec_imm,
	output logic [`SLURM_BITS - 1:0]          retire_instr,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  retire_pc
);
	import slurm16_isa_pkg::*;

	logic [`SLURM_ADDRESS_BITS - 1:0] fetch_pc, branch_target, pc_stage2;
	logic fetch_valid, stall, stall_start, stall_end, hazard1, load_pc;
	logic [`SLURM_BITS - 1:0] stage0, stage1, stage3;
	reg_idx_t hazard_reg0, hazard_reg1, hazard_reg2, hazard_reg3;
	logic modifies_flags0, modifies_flags1, modifies_flags2, modifies_flags3;

	slurm16_fetch u_fetch (
		.CLK(CLK), .RSTb(RSTb), .run(run), .stall(stall), .load_pc(load_pc),
		.branch_target(branch_target), .fetch_addr(mem_addr), .fetch_pc(fetch_pc),
		.fetch_valid(fetch_valid)
	);

	slurm16_cpu_pipeline u_pipe (
		.CLK(CLK), .RSTb(RSTb), .memory_in(mem_data), .memory_address(fetch_pc),
		.memory_is_instruction(fetch_valid), .is_executing(run),
		.stall(stall), .stall_start(stall_start), .stall_end(stall_end), .load_pc(load_pc),
		.hazard_reg0(hazard_reg0), .modifies_flags0(modifies_flags0), .hazard1(hazard1),
		.interrupt_flag_set(int_flag_set), .interrupt_flag_clear(int_flag_clear),
		.interrupt(interrupt), .irq(irq),
		.pipeline_stage0(stage0), .pipeline_stage1(stage1), .pipeline_stage2(exec_instr),
		.pipeline_stage3(stage3), .pipeline_stage4(retire_instr),
		.pc_stage2(pc_stage2), .pc_stage4(retire_pc), .imm_reg(exec_imm),
		.hazard_reg1(hazard_reg1), .hazard_reg2(hazard_reg2), .hazard_reg3(hazard_reg3),
		.modifies_flags1(modifies_flags1), .modifies_flags2(modifies_flags2),
		.modifies_flags3(modifies_flags3)
	);

	slurm16_hazard_ctl u_hazard (
		.CLK(CLK), .RSTb(RSTb), .is_executing(run),
		.pipeline_stage0(stage0), .pipeline_stage1(stage1),
		.pipeline_stage2(exec_instr), .pipeline_stage3(stage3), .pc_stage2(pc_stage2),
		.hazard_reg1(hazard_reg1), .hazard_reg2(hazard_reg2), .hazard_reg3(hazard_reg3),
		.modifies_flags1(modifies_flags1), .modifies_flags2(modifies_flags2),
		.modifies_flags3(modifies_flags3),
		.hazard_reg0(hazard_reg0), .modifies_flags0(modifies_flags0),
		.stall(stall), .stall_start(stall_start), .stall_end(stall_end),
		.hazard1(hazard1), .load_pc(load_pc), .branch_target(branch_target)
	);

endmodule

// ==== verification/slurm16_frontend_chk.sv ====
`timescale 1ns/1ps
`include "slurm16_config.svh"

module slurm16_frontend_chk (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  logic                      stall,
	input  logic                      stall_start,
	input  logic                      stall_end,
	input  logic                      load_pc,
	input  logic [`SLURM_BITS - 1:0]  pipeline_stage2
);
	import slurm16_isa_pkg::*;

	int fails = 0;

	// Stall edges are single-cycle pulses
	a_start_pulse: assert property (@(posedge CLK) disable iff (!RSTb)
		stall_start |=> !stall_start)
		else begin
			$error("stall_start high for more than one cycle");
			fails++;
		end

	a_end_pulse: assert property (@(posedge CLK) disable iff (!RSTb)
		stall_end |=> !stall_end)
		else begin
			$error("stall_end high for more than one cycle");
			fails++;
		end

	// Branch flush empties execute
	a_flush_exec: assert property (@(posedge CLK) disable iff (!RSTb)
		load_pc |=> pipeline_stage2 == NOP_INSTRUCTION)
		else begin
			$error("Stage 2 not flushed after load_pc");
			fails++;
		end

	a_reset_stall: assert property (@(posedge CLK) !RSTb |=> !stall)
		else begin
			$error("stall high right after reset");
			fails++;
		end

endmodule

bind slurm16_cpu_pipeline slurm16_frontend_chk u_chk (
	.CLK(CLK), .RSTb(RSTb), .stall(stall), .stall_start(stall_start),
	.stall_end(stall_end), .load_pc(load_pc), .pipeline_stage2(pipeline_stage2)
);

// ==== verification/tb_slurm16_frontend.sv ====
`timescale 1ns/1ps
`include "slurm16_config.svh"

module tb_slurm16_frontend;
	import slurm16_isa_pkg::*;

	localparam int PROG_LEN = 160;
	localparam int MEM_DEPTH = 512;
	localparam int RUN_TIMEOUT = 4000;
	localparam int INT_TIMEOUT = 40;

	logic CLK, RSTb, run, interrupt, int_flag_set, int_flag_clear;
	logic [3:0] irq;
	logic [`SLURM_BITS - 1:0] mem_data, exec_instr, exec_imm, retire_instr;
	logic [`SLURM_ADDRESS_BITS - 1:0] mem_addr, retire_pc, read_addr;

	logic [`SLURM_BITS - 1:0] mem [MEM_DEPTH];
	logic [`SLURM_BITS - 1:0] exp_word [$];
	logic [`SLURM_ADDRESS_BITS - 1:0] exp_pc [$];
	logic [`SLURM_BITS - 1:0] exp_imm [$];
	bit exp_imm_valid [$];

	integer seed;
	int errors, retire_idx, exec_idx, int_count, int_base, cycles;
	logic [3:0] last_irq, irq_sel;

	slurm16_frontend u_dut (
		.CLK(CLK), .RSTb(RSTb), .run(run), .mem_data(mem_data), .interrupt(interrupt),
		.irq(irq), .int_flag_set(int_flag_set), .int_flag_clear(int_flag_clear),
		.mem_addr(mem_addr), .exec_instr(exec_instr), .exec_imm(exec_imm),
		.retire_instr(retire_instr), .retire_pc(retire_pc)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Synchronous instruction memory with one cycle of latency
	always @(negedge CLK)
		read_addr <= mem_addr;
	always @(posedge CLK) begin
		#2;
		mem_data = (read_addr < MEM_DEPTH) ? mem[read_addr[8:0]] : NOP_INSTRUCTION;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic build_program();
		int kind;
		logic [3:0] dst, src;
		logic [7:0] off;
		for (int a = 0; a < MEM_DEPTH; a++) begin
			kind = {$random(seed)} % 16;
			dst = 4'(1 + {$random(seed)} % 3); // Few registers so hazards are frequent
			src = 4'({$random(seed)} % 4);
			off = 8'(1 + {$random(seed)} % 3);
			if (a >= PROG_LEN || kind < 2)
				mem[a] = NOP_INSTRUCTION;
			else if (kind < 4)
				mem[a] = {4'(OP_IMM), 12'({$random(seed)})};
			else if (kind < 9)
				mem[a] = {4'(OP_ALU), 4'h0, dst, src};
			else if (kind < 13)
				mem[a] = {4'(OP_MOV), 4'h0, dst, src};
			else if (a + 1 + off < PROG_LEN)
				mem[a] = {4'(OP_BR), 4'h0, off}; // Forward branch with its target inside the program
			else
				mem[a] = NOP_INSTRUCTION;
		end
	endtask

	// Walk the program as executed so taken branches skip the flushed words
	task automatic build_model();
		int pc;
		logic [`SLURM_BITS - 1:0] w, last;
		pc = 0;
		last = NOP_INSTRUCTION;
		while (pc < PROG_LEN) begin
			w = mem[pc];
			if (w != NOP_INSTRUCTION) begin
				exp_word.push_back(w);
				exp_pc.push_back(`SLURM_ADDRESS_BITS'(pc));
				exp_imm_valid.push_back(last[15:12] == 4'(OP_IMM));
				exp_imm.push_back({last[11:0], w[3:0]});
				last = w;
			end
			if (w[15:12] == 4'(OP_BR))
				pc = pc + 1 + int'(w[7:0]);
			else
				pc = pc + 1;
		end
	endtask

	// Retire and execute monitor
	always @(negedge CLK) begin
		if (RSTb) begin
			if (retire_instr != NOP_INSTRUCTION) begin
				if (retire_instr[15:4] == INT_PREFIX) begin
					int_count++;
					last_irq = retire_instr[3:0];
				end else if (retire_idx < exp_word.size()) begin
					check_value("retire_instr", retire_instr, exp_word[retire_idx]);
					check_value("retire_pc", retire_pc, exp_pc[retire_idx]);
					retire_idx++;
				end else begin
					$display("Word %h retired at address %h after the end of the program",
						retire_instr, retire_pc);
					errors++;
				end
			end
			if (exec_instr != NOP_INSTRUCTION && exec_instr[15:4] != INT_PREFIX) begin
				if (exec_idx < exp_word.size()) begin
					check_value("exec_instr", exec_instr, exp_word[exec_idx]);
					if (exp_imm_valid[exec_idx])
						check_value("exec_imm", exec_imm, exp_imm[exec_idx]);
					exec_idx++;
				end else begin
					$display("Word %h reached execute after the end of the program", exec_instr);
					errors++;
				end
			end
		end
	end

	initial begin
		RSTb = 1'b0;
		run = 1'b0;
		interrupt = 1'b0;
		irq = 4'h0;
		int_flag_set = 1'b0;
		int_flag_clear = 1'b0;
		mem_data = NOP_INSTRUCTION;
		read_addr = '0;
		errors = 0;
		retire_idx = 0;
		exec_idx = 0;
		int_count = 0;
		last_irq = 4'h0;
		seed = 32'hfe4a_dde2;
		build_program();
		build_model();

		repeat (3) @(posedge CLK);
		#2;
		check_value("mem_addr", mem_addr, '0);
		RSTb = 1'b1;
		run = 1'b1;
		for (int i = 0; i < 4; i++) begin
			@(negedge CLK);
			check_value("retire_instr", retire_instr, NOP_INSTRUCTION);
		end

		cycles = 0;
		while (retire_idx < exp_word.size() && cycles < RUN_TIMEOUT) begin
			@(posedge CLK);
			cycles++;
		end
		if (retire_idx < exp_word.size()) begin
			$display("Timeout: only %0d of %0d words retired", retire_idx, exp_word.size());
			errors++;
		end
		repeat (10) @(posedge CLK); // Nothing else from the program may show up
		check_value("exec count", exec_idx, exp_word.size());

		// One INT per armed interrupt
		int_base = int_count;
		#2 int_flag_set = 1'b1;
		@(posedge CLK);
		#2 int_flag_set = 1'b0;
		irq_sel = 4'($random(seed));
		irq = irq_sel;
		interrupt = 1'b1;
		cycles = 0;
		while (int_count == int_base && cycles < INT_TIMEOUT) begin
			@(posedge CLK);
			cycles++;
		end
		#2 interrupt = 1'b0;
		if (int_count == int_base) begin
			$display("Timeout: no INT retired after the interrupt was raised");
			errors++;
		end
		repeat (20) @(posedge CLK);
		check_value("int count", int_count, int_base + 1);
		check_value("int irq", last_irq, irq_sel);

		// Cleared flag blocks the interrupt
		int_base = int_count;
		#2 int_flag_set = 1'b1;
		@(posedge CLK);
		#2 int_flag_set = 1'b0;
		int_flag_clear = 1'b1;
		@(posedge CLK);
		#2 int_flag_clear = 1'b0;
		interrupt = 1'b1;
		repeat (20) @(posedge CLK);
		#2 interrupt = 1'b0;
		repeat (10) @(posedge CLK);
		check_value("int count", int_count, int_base);

		errors = errors + u_dut.u_pipe.u_chk.fails;
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+logic
logic/slurm16_isa_pkg.sv
logic/slurm16_pipe_pkg.sv
logic/slurm16_fetch.sv
logic/slurm16_hazard_ctl.sv
logic/slurm16_cpu_pipeline.sv
logic/slurm16_frontend.sv
verification/slurm16_frontend_chk.sv
verification/tb_slurm16_frontend.sv

// ==== Makefile ====
TOP = tb_slurm16_frontend

all: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build lint clean
